// File: Makefile
TOP := exu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f sim.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

// File: design/exu_alu.sv
`default_nettype none
`timescale 1ns/1ps

module exu_alu
    import rv_isa_pkg::*;
    import exu_decinfo_pkg::*;
(
    input  logic                req_alu_i,
    input  logic [XLEN-1:0]     alu_op1_i,
    input  logic [XLEN-1:0]     alu_op2_i,
    input  logic [ALU_OP_W-1:0] alu_op_info_i,
    output logic [XLEN-1:0]     alu_res_o
);

    logic [XLEN-1:0] add_res;
    logic [XLEN-1:0] res;
    logic [4:0]      shamt;

    assign add_res = alu_op1_i + alu_op2_i;  // ADD, LUI (0 + imm), AUIPC, link
    assign shamt   = alu_op2_i[4:0];         // RV32I uses low 5 bits

    always_comb begin
        res = '0;
        if (alu_op_info_i[ALU_OP_ADD] | alu_op_info_i[ALU_OP_LUI] |
            alu_op_info_i[ALU_OP_AUIPC] | alu_op_info_i[ALU_OP_JUMP]) begin
            res = add_res;
        end
        if (alu_op_info_i[ALU_OP_SUB]) begin
            res = alu_op1_i - alu_op2_i;
        end
        if (alu_op_info_i[ALU_OP_SLL]) begin
            res = alu_op1_i << shamt;
        end
        if (alu_op_info_i[ALU_OP_SLT]) begin
            res = {{(XLEN-1){1'b0}}, $signed(alu_op1_i) < $signed(alu_op2_i)};
        end
        if (alu_op_info_i[ALU_OP_SLTU]) begin
            res = {{(XLEN-1){1'b0}}, alu_op1_i < alu_op2_i};
        end
        if (alu_op_info_i[ALU_OP_XOR]) begin
            res = alu_op1_i ^ alu_op2_i;
        end
        if (alu_op_info_i[ALU_OP_SRL]) begin
            res = alu_op1_i >> shamt;
        end
        if (alu_op_info_i[ALU_OP_SRA]) begin
            res = $unsigned($signed(alu_op1_i) >>> shamt); // Sign fill
        end
        if (alu_op_info_i[ALU_OP_OR]) begin
            res = alu_op1_i | alu_op2_i;
        end
        if (alu_op_info_i[ALU_OP_AND]) begin
            res = alu_op1_i & alu_op2_i;
        end
    end

    assign alu_res_o = req_alu_i ? res : '0;

endmodule

`default_nettype wire

// File: design/exu_bru.sv
`default_nettype none
`timescale 1ns/1ps

module exu_bru
    import rv_isa_pkg::*;
(
    input  logic            req_bjp_i,
    input  logic [XLEN-1:0] bjp_op1_i,       // rs1 for compare
    input  logic [XLEN-1:0] bjp_op2_i,       // rs2 for compare
    input  logic [XLEN-1:0] bjp_jump_op1_i,  // PC or rs1
    input  logic [XLEN-1:0] bjp_jump_op2_i,  // Offset
    input  logic            bjp_op_jump_i,
    input  logic            bjp_op_beq_i,
    input  logic            bjp_op_bne_i,
    input  logic            bjp_op_blt_i,
    input  logic            bjp_op_bltu_i,
    input  logic            bjp_op_bge_i,
    input  logic            bjp_op_bgeu_i,
    output logic            bjp_taken_o,
    output logic [XLEN-1:0] bjp_target_o
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] sum;

    assign eq   = (bjp_op1_i == bjp_op2_i);
    assign lt_s = ($signed(bjp_op1_i) < $signed(bjp_op2_i));
    assign lt_u = (bjp_op1_i < bjp_op2_i);
    assign sum  = bjp_jump_op1_i + bjp_jump_op2_i;

    assign bjp_taken_o = req_bjp_i & (bjp_op_jump_i |             // Jumps always taken
                         (bjp_op_beq_i & eq)    | (bjp_op_bne_i & ~eq) |
                         (bjp_op_blt_i & lt_s)  | (bjp_op_bge_i & ~lt_s) |
                         (bjp_op_bltu_i & lt_u) | (bjp_op_bgeu_i & ~lt_u));

    // Clearing bit 0 on any jump only matters for JALR
    assign bjp_target_o = req_bjp_i ? {sum[XLEN-1:1], sum[0] & ~bjp_op_jump_i} : '0;

endmodule

`default_nettype wire

// File: design/exu_decinfo_pkg.sv
`default_nettype none

package exu_decinfo_pkg;

    localparam int DECINFO_GRP_W   = 3;
    localparam int DECINFO_GRP_LSB = 0;
    localparam int DECINFO_GRP_MSB = DECINFO_GRP_LSB + DECINFO_GRP_W - 1;

    // Functional group of a decoded instruction
    typedef enum logic [DECINFO_GRP_W-1:0] {
        GRP_ALU    = 3'd0,
        GRP_BJP    = 3'd1,
        GRP_MULDIV = 3'd2, // Not built here
        GRP_CSR    = 3'd3, // Not built here
        GRP_MEM    = 3'd4, // Not built here
        GRP_SYS    = 3'd5
    } dec_grp_e;

    // Sized for the CSR group, 4 flags plus a 12-bit address
    localparam int DECINFO_W = 19;

    // ALU group flags
    localparam int DECINFO_ALU_OP2IMM = 3;  // Operand 2 is the immediate
    localparam int DECINFO_ALU_OP1PC  = 4;  // Operand 1 is the PC
    localparam int DECINFO_ALU_LUI    = 5;
    localparam int DECINFO_ALU_AUIPC  = 6;
    localparam int DECINFO_ALU_ADD    = 7;
    localparam int DECINFO_ALU_SUB    = 8;
    localparam int DECINFO_ALU_SLL    = 9;
    localparam int DECINFO_ALU_SLT    = 10;
    localparam int DECINFO_ALU_SLTU   = 11;
    localparam int DECINFO_ALU_XOR    = 12;
    localparam int DECINFO_ALU_SRL    = 13;
    localparam int DECINFO_ALU_SRA    = 14;
    localparam int DECINFO_ALU_OR     = 15;
    localparam int DECINFO_ALU_AND    = 16;

    // Branch/jump group flags
    localparam int DECINFO_BJP_JUMP   = 3;  // JAL or JALR
    localparam int DECINFO_BJP_OP1RS1 = 4;  // Jump base is rs1, JALR
    localparam int DECINFO_BJP_BEQ    = 5;
    localparam int DECINFO_BJP_BNE    = 6;
    localparam int DECINFO_BJP_BLT    = 7;
    localparam int DECINFO_BJP_BLTU   = 8;
    localparam int DECINFO_BJP_BGE    = 9;
    localparam int DECINFO_BJP_BGEU   = 10;

    // System group flags
    localparam int DECINFO_SYS_NOP     = 3; // FENCE.I, nothing to flush
    localparam int DECINFO_SYS_MRET    = 4;
    localparam int DECINFO_SYS_ECALL   = 5;
    localparam int DECINFO_SYS_EBREAK  = 6;
    localparam int DECINFO_SYS_FENCE   = 7;
    localparam int DECINFO_SYS_ILLEGAL = 8;

    localparam int ALU_OP_W = 13;

    // Bit index into the one-hot ALU op-info
    typedef enum logic [3:0] {
        ALU_OP_ADD   = 4'd0,
        ALU_OP_SUB   = 4'd1,
        ALU_OP_SLL   = 4'd2,
        ALU_OP_SLT   = 4'd3,
        ALU_OP_SLTU  = 4'd4,
        ALU_OP_XOR   = 4'd5,
        ALU_OP_SRL   = 4'd6,
        ALU_OP_SRA   = 4'd7,
        ALU_OP_OR    = 4'd8,
        ALU_OP_AND   = 4'd9,
        ALU_OP_LUI   = 4'd10,
        ALU_OP_AUIPC = 4'd11,
        ALU_OP_JUMP  = 4'd12  // Link address PC + 4
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/exu_dispatch.sv
`default_nettype none
`timescale 1ns/1ps

module exu_dispatch
    import exu_decinfo_pkg::*;
(
    input  logic [DECINFO_W-1:0] dec_info_bus_i,
    input  logic [31:0]          dec_imm_i,
    input  logic [31:0]          dec_pc_i,
    input  logic [31:0]          rs1_rdata_i,
    input  logic [31:0]          rs2_rdata_i,

    output logic                 req_alu_o,
    output logic [31:0]          alu_op1_o,
    output logic [31:0]          alu_op2_o,
    output logic [ALU_OP_W-1:0]  alu_op_info_o,

    output logic                 req_bjp_o,
    output logic [31:0]          bjp_op1_o,
    output logic [31:0]          bjp_op2_o,
    output logic [31:0]          bjp_jump_op1_o,
    output logic [31:0]          bjp_jump_op2_o,
    output logic                 bjp_op_jump_o,
    output logic                 bjp_op_beq_o,
    output logic                 bjp_op_bne_o,
    output logic                 bjp_op_blt_o,
    output logic                 bjp_op_bltu_o,
    output logic                 bjp_op_bge_o,
    output logic                 bjp_op_bgeu_o,

    output logic                 sys_op_mret_o,
    output logic                 sys_op_ecall_o,
    output logic                 sys_op_ebreak_o,
    output logic                 sys_op_fence_o,
    output logic                 sys_op_illegal_o
);

    logic [DECINFO_GRP_W-1:0] grp;
    logic                     op_alu;
    logic                     op_bjp;
    logic                     op_sys;
    logic [DECINFO_W-1:0]     alu_info;
    logic [DECINFO_W-1:0]     bjp_info;
    logic [DECINFO_W-1:0]     sys_info;
    logic [31:0]              alu_op1;

    assign grp    = dec_info_bus_i[DECINFO_GRP_MSB:DECINFO_GRP_LSB];
    assign op_alu = (grp == GRP_ALU);
    assign op_bjp = (grp == GRP_BJP);
    assign op_sys = (grp == GRP_SYS);

    // Flag bits are shared between groups, mask with the group match
    assign alu_info = {DECINFO_W{op_alu}} & dec_info_bus_i;
    assign bjp_info = {DECINFO_W{op_bjp}} & dec_info_bus_i;
    assign sys_info = {DECINFO_W{op_sys}} & dec_info_bus_i;

    // ALU operands, jumps borrow the ALU for the link address
    assign alu_op1 = (alu_info[DECINFO_ALU_OP1PC] | bjp_op_jump_o) ? dec_pc_i :
                     alu_info[DECINFO_ALU_LUI] ? 32'h0 : rs1_rdata_i;
    assign alu_op1_o = (op_alu | bjp_op_jump_o) ? alu_op1 : 32'h0;
    assign alu_op2_o = bjp_op_jump_o ? 32'h4 :                         // PC + 4
                       !op_alu ? 32'h0 :
                       alu_info[DECINFO_ALU_OP2IMM] ? dec_imm_i : rs2_rdata_i;
    assign req_alu_o = op_alu | bjp_op_jump_o;

    always_comb begin
        alu_op_info_o               = '0;
        alu_op_info_o[ALU_OP_ADD]   = alu_info[DECINFO_ALU_ADD];
        alu_op_info_o[ALU_OP_SUB]   = alu_info[DECINFO_ALU_SUB];
        alu_op_info_o[ALU_OP_SLL]   = alu_info[DECINFO_ALU_SLL];
        alu_op_info_o[ALU_OP_SLT]   = alu_info[DECINFO_ALU_SLT];
        alu_op_info_o[ALU_OP_SLTU]  = alu_info[DECINFO_ALU_SLTU];
        alu_op_info_o[ALU_OP_XOR]   = alu_info[DECINFO_ALU_XOR];
        alu_op_info_o[ALU_OP_SRL]   = alu_info[DECINFO_ALU_SRL];
        alu_op_info_o[ALU_OP_SRA]   = alu_info[DECINFO_ALU_SRA];
        alu_op_info_o[ALU_OP_OR]    = alu_info[DECINFO_ALU_OR];
        alu_op_info_o[ALU_OP_AND]   = alu_info[DECINFO_ALU_AND];
        alu_op_info_o[ALU_OP_LUI]   = alu_info[DECINFO_ALU_LUI];
        alu_op_info_o[ALU_OP_AUIPC] = alu_info[DECINFO_ALU_AUIPC];
        alu_op_info_o[ALU_OP_JUMP]  = bjp_op_jump_o;
    end

    // Branch compare operands and jump base/offset
    assign req_bjp_o      = op_bjp;
    assign bjp_op1_o      = op_bjp ? rs1_rdata_i : 32'h0;
    assign bjp_op2_o      = op_bjp ? rs2_rdata_i : 32'h0;
    assign bjp_jump_op1_o = !op_bjp ? 32'h0 :
                            bjp_info[DECINFO_BJP_OP1RS1] ? rs1_rdata_i : dec_pc_i; // JALR base
    assign bjp_jump_op2_o = op_bjp ? dec_imm_i : 32'h0;
    assign bjp_op_jump_o  = bjp_info[DECINFO_BJP_JUMP];
    assign bjp_op_beq_o   = bjp_info[DECINFO_BJP_BEQ];
    assign bjp_op_bne_o   = bjp_info[DECINFO_BJP_BNE];
    assign bjp_op_blt_o   = bjp_info[DECINFO_BJP_BLT];
    assign bjp_op_bltu_o  = bjp_info[DECINFO_BJP_BLTU];
    assign bjp_op_bge_o   = bjp_info[DECINFO_BJP_BGE];
    assign bjp_op_bgeu_o  = bjp_info[DECINFO_BJP_BGEU];

    assign sys_op_mret_o    = sys_info[DECINFO_SYS_MRET];
    assign sys_op_ecall_o   = sys_info[DECINFO_SYS_ECALL];
    assign sys_op_ebreak_o  = sys_info[DECINFO_SYS_EBREAK];
    assign sys_op_fence_o   = sys_info[DECINFO_SYS_FENCE];
    assign sys_op_illegal_o = sys_info[DECINFO_SYS_ILLEGAL];

endmodule

`default_nettype wire

// File: design/exu_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module exu_regfile
    import rv_isa_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic [XLEN-1:0]       rd_data_i,
    output logic [XLEN-1:0]       rs1_rdata_o,
    output logic [XLEN-1:0]       rs2_rdata_o
);

    logic [XLEN-1:0] regs [1:31]; // No storage for x0

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // Combinational reads, x0 hardwired
    assign rs1_rdata_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_rdata_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: design/exu_top.sv
`default_nettype none
`timescale 1ns/1ps

module exu_top
    import rv_isa_pkg::*;
    import exu_decinfo_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  inst_valid_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    output logic [4:0]            sys_evt_o      // {ILLEGAL, FENCE, MRET, EBREAK, ECALL}
);

    logic [DECINFO_W-1:0]  dec_info_bus;
    logic [XLEN-1:0]       dec_imm;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic                  req_alu;
    logic [XLEN-1:0]       alu_op1;
    logic [XLEN-1:0]       alu_op2;
    logic [ALU_OP_W-1:0]   alu_op_info;
    logic [XLEN-1:0]       alu_res;
    logic                  req_bjp;
    logic [XLEN-1:0]       bjp_op1;
    logic [XLEN-1:0]       bjp_op2;
    logic [XLEN-1:0]       bjp_jump_op1;
    logic [XLEN-1:0]       bjp_jump_op2;
    logic                  bjp_op_jump;
    logic [5:0]            bjp_br;        // {bgeu, bge, bltu, blt, bne, beq}
    logic                  bjp_taken;
    logic [XLEN-1:0]       bjp_target;
    logic [4:0]            sys_evt;
    logic                  rf_we;
    logic                  take_redirect;

    idu_decode u_decode (
        .inst_i         (inst_i),
        .dec_info_bus_o (dec_info_bus),
        .dec_imm_o      (dec_imm),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rd_addr_o      (rd_addr)
    );

    exu_regfile u_regfile (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .we_i        (rf_we),
        .rd_addr_i   (rd_addr),
        .rd_data_i   (alu_res),
        .rs1_rdata_o (rs1_rdata),
        .rs2_rdata_o (rs2_rdata)
    );

    exu_dispatch u_dispatch (
        .dec_info_bus_i   (dec_info_bus),
        .dec_imm_i        (dec_imm),
        .dec_pc_i         (pc_i),
        .rs1_rdata_i      (rs1_rdata),
        .rs2_rdata_i      (rs2_rdata),
        .req_alu_o        (req_alu),
        .alu_op1_o        (alu_op1),
        .alu_op2_o        (alu_op2),
        .alu_op_info_o    (alu_op_info),
        .req_bjp_o        (req_bjp),
        .bjp_op1_o        (bjp_op1),
        .bjp_op2_o        (bjp_op2),
        .bjp_jump_op1_o   (bjp_jump_op1),
        .bjp_jump_op2_o   (bjp_jump_op2),
        .bjp_op_jump_o    (bjp_op_jump),
        .bjp_op_beq_o     (bjp_br[0]),
        .bjp_op_bne_o     (bjp_br[1]),
        .bjp_op_blt_o     (bjp_br[2]),
        .bjp_op_bltu_o    (bjp_br[3]),
        .bjp_op_bge_o     (bjp_br[4]),
        .bjp_op_bgeu_o    (bjp_br[5]),
        .sys_op_ecall_o   (sys_evt[0]),
        .sys_op_ebreak_o  (sys_evt[1]),
        .sys_op_mret_o    (sys_evt[2]),
        .sys_op_fence_o   (sys_evt[3]),
        .sys_op_illegal_o (sys_evt[4])
    );

    exu_alu u_alu (
        .req_alu_i     (req_alu),
        .alu_op1_i     (alu_op1),
        .alu_op2_i     (alu_op2),
        .alu_op_info_i (alu_op_info),
        .alu_res_o     (alu_res)
    );

    exu_bru u_bru (
        .req_bjp_i      (req_bjp),
        .bjp_op1_i      (bjp_op1),
        .bjp_op2_i      (bjp_op2),
        .bjp_jump_op1_i (bjp_jump_op1),
        .bjp_jump_op2_i (bjp_jump_op2),
        .bjp_op_jump_i  (bjp_op_jump),
        .bjp_op_beq_i   (bjp_br[0]),
        .bjp_op_bne_i   (bjp_br[1]),
        .bjp_op_blt_i   (bjp_br[2]),
        .bjp_op_bltu_i  (bjp_br[3]),
        .bjp_op_bge_i   (bjp_br[4]),
        .bjp_op_bgeu_i  (bjp_br[5]),
        .bjp_taken_o    (bjp_taken),
        .bjp_target_o   (bjp_target)
    );

    // ALU ops and jump links write rd, x0 writes dropped
    assign rf_we         = inst_valid_i & req_alu & (rd_addr != '0);
    assign take_redirect = inst_valid_i & bjp_taken;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o    <= 1'b0;
            wb_rd_o       <= '0;
            wb_data_o     <= '0;
            redirect_o    <= 1'b0;
            redirect_pc_o <= '0;
            sys_evt_o     <= '0;
        end else begin
            wb_valid_o    <= rf_we;
            wb_rd_o       <= rf_we ? rd_addr : '0;       // Zero when idle
            wb_data_o     <= rf_we ? alu_res : '0;
            redirect_o    <= take_redirect;
            redirect_pc_o <= take_redirect ? bjp_target : '0;
            sys_evt_o     <= inst_valid_i ? sys_evt : '0;  // One pulse per event
        end
    end

endmodule

`default_nettype wire

// File: design/idu_decode.sv
`default_nettype none
`timescale 1ns/1ps

module idu_decode
    import rv_isa_pkg::*;
    import exu_decinfo_pkg::*;
(
    input  logic [XLEN-1:0]       inst_i,
    output logic [DECINFO_W-1:0]  dec_info_bus_o,
    output logic [XLEN-1:0]       dec_imm_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            f7_ok;   // funct7 legal for OP and shifts
    logic            is_sub;  // SUB or SRA variant
    logic            illegal;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign f7_ok  = (funct7 == 7'h00) |
                    ((funct7 == 7'h20) & ((funct3 == 3'b000) | (funct3 == 3'b101)));
    assign is_sub = (opcode == OP) & funct7[5]; // ADDI keeps bit 30 as imm

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    always_comb begin
        dec_info_bus_o = '0;
        dec_imm_o      = '0;
        illegal        = 1'b0;
        case (opcode)
            OP, OP_IMM: begin
                dec_info_bus_o[DECINFO_GRP_MSB:DECINFO_GRP_LSB] = GRP_ALU;
                dec_info_bus_o[DECINFO_ALU_OP2IMM] = (opcode == OP_IMM);
                dec_imm_o = imm_i;
                illegal   = ((opcode == OP) | (funct3[1:0] == 2'b01)) & ~f7_ok; // Shifts check funct7
                case (funct3)
                    3'b000: begin
                        dec_info_bus_o[DECINFO_ALU_ADD] = ~is_sub;
                        dec_info_bus_o[DECINFO_ALU_SUB] = is_sub;
                    end
                    3'b001: dec_info_bus_o[DECINFO_ALU_SLL]  = 1'b1;
                    3'b010: dec_info_bus_o[DECINFO_ALU_SLT]  = 1'b1;
                    3'b011: dec_info_bus_o[DECINFO_ALU_SLTU] = 1'b1;
                    3'b100: dec_info_bus_o[DECINFO_ALU_XOR]  = 1'b1;
                    3'b101: begin
                        dec_info_bus_o[DECINFO_ALU_SRL] = ~funct7[5];
                        dec_info_bus_o[DECINFO_ALU_SRA] = funct7[5]; // Also SRAI
                    end
                    3'b110: dec_info_bus_o[DECINFO_ALU_OR]   = 1'b1;
                    default: dec_info_bus_o[DECINFO_ALU_AND] = 1'b1;
                endcase
            end
            LUI, AUIPC: begin
                dec_info_bus_o[DECINFO_GRP_MSB:DECINFO_GRP_LSB] = GRP_ALU;
                dec_info_bus_o[DECINFO_ALU_OP2IMM] = 1'b1;
                dec_info_bus_o[DECINFO_ALU_LUI]    = (opcode == LUI);   // Op1 forced zero
                dec_info_bus_o[DECINFO_ALU_AUIPC]  = (opcode == AUIPC);
                dec_info_bus_o[DECINFO_ALU_OP1PC]  = (opcode == AUIPC);
                dec_imm_o = imm_u;
            end
            JAL, JALR: begin
                dec_info_bus_o[DECINFO_GRP_MSB:DECINFO_GRP_LSB] = GRP_BJP;
                dec_info_bus_o[DECINFO_BJP_JUMP]   = 1'b1;
                dec_info_bus_o[DECINFO_BJP_OP1RS1] = (opcode == JALR);
                dec_imm_o = (opcode == JALR) ? imm_i : imm_j;
                illegal   = (opcode == JALR) & (funct3 != 3'b000);
            end
            BRANCH: begin
                dec_info_bus_o[DECINFO_GRP_MSB:DECINFO_GRP_LSB] = GRP_BJP;
                dec_imm_o = imm_b;
                case (funct3)
                    3'b000: dec_info_bus_o[DECINFO_BJP_BEQ]  = 1'b1;
                    3'b001: dec_info_bus_o[DECINFO_BJP_BNE]  = 1'b1;
                    3'b100: dec_info_bus_o[DECINFO_BJP_BLT]  = 1'b1;
                    3'b101: dec_info_bus_o[DECINFO_BJP_BGE]  = 1'b1;
                    3'b110: dec_info_bus_o[DECINFO_BJP_BLTU] = 1'b1;
                    3'b111: dec_info_bus_o[DECINFO_BJP_BGEU] = 1'b1;
                    default: illegal = 1'b1;                // 010, 011 reserved
                endcase
            end
            SYSTEM: begin
                dec_info_bus_o[DECINFO_GRP_MSB:DECINFO_GRP_LSB] = GRP_SYS;
                case (inst_i)
                    32'h0000_0073: dec_info_bus_o[DECINFO_SYS_ECALL]  = 1'b1;
                    32'h0010_0073: dec_info_bus_o[DECINFO_SYS_EBREAK] = 1'b1;
                    32'h3020_0073: dec_info_bus_o[DECINFO_SYS_MRET]   = 1'b1;
                    default: illegal = 1'b1;                // CSR ops unsupported
                endcase
            end
            MISC_MEM: begin
                dec_info_bus_o[DECINFO_GRP_MSB:DECINFO_GRP_LSB] = GRP_SYS;
                dec_info_bus_o[DECINFO_SYS_FENCE] = (funct3 == 3'b000);
                dec_info_bus_o[DECINFO_SYS_NOP]   = (funct3 == 3'b001); // FENCE.I
                illegal = funct3[2:1] != 2'b00;
            end
            default: illegal = 1'b1;                        // LOAD, STORE, unknown
        endcase

        if (illegal) begin                                  // Overrides any partial decode
            dec_info_bus_o = '0;
            dec_imm_o      = '0;
            dec_info_bus_o[DECINFO_GRP_MSB:DECINFO_GRP_LSB] = GRP_SYS;
            dec_info_bus_o[DECINFO_SYS_ILLEGAL] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN       = 32; // Data path width
    localparam int REG_ADDR_W = 5;  // x0..x31

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP       = 7'b0110011, // Reg-reg ALU
        OP_IMM   = 7'b0010011, // Reg-imm ALU
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        SYSTEM   = 7'b1110011, // ECALL, EBREAK, MRET, CSR
        MISC_MEM = 7'b0001111, // FENCE, FENCE.I
        LOAD     = 7'b0000011, // No LSU in this slice
        STORE    = 7'b0100011
    } rv_opcode_e;

endpackage

`default_nettype wire

// File: sim.f
design/rv_isa_pkg.sv
design/exu_decinfo_pkg.sv
design/idu_decode.sv
design/exu_dispatch.sv
design/exu_alu.sv
design/exu_bru.sv
design/exu_regfile.sv
design/exu_top.sv
tb/exu_chk.sv
tb/exu_tb.sv

// File: tb/exu_chk.sv
`default_nettype none
`timescale 1ns/1ps

module exu_chk (
    input logic       clk_i,
    input logic       arst_n_i,
    input logic       inst_valid_i,
    input logic       wb_valid_i,
    input logic [4:0] wb_rd_i,
    input logic       redirect_i,
    input logic [4:0] sys_evt_i
);

    // No strobe, nothing may come out next cycle
    idle_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !inst_valid_i |=> (!wb_valid_i && !redirect_i))
        else $error("Writeback or redirect after a cycle without a strobe");

    sys_evt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(sys_evt_i))
        else $error("More than one system event at once");

    // x0 writes never reach the writeback port
    wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_i |-> (wb_rd_i != 5'd0))
        else $error("Writeback valid with rd equal to x0");

endmodule

bind exu_top exu_chk i_chk (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o),
    .redirect_i   (redirect_o),
    .sys_evt_i    (sys_evt_o)
);

`default_nettype wire

// File: tb/exu_tb.sv
`default_nettype none
`timescale 1ns/1ps

module exu_tb;

    localparam int    CLK_PERIOD      = 8;
    localparam int    CYCLES_PER_TEST = 40;                 // Watchdog budget per test line
    localparam string TEST_FILE       = "tb/exu_tests.txt";

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [4:0]  sys_evt;

    // One entry per test line, columns as in the file
    logic [31:0] t_inst[$];
    logic [31:0] t_pc[$];
    logic [31:0] t_wb_valid[$];
    logic [31:0] t_wb_rd[$];
    logic [31:0] t_wb_data[$];
    logic [31:0] t_redir[$];
    logic [31:0] t_redir_pc[$];
    logic [31:0] t_sys[$];

    int seed = 93;
    int cur_test;                                           // For error lines
    bit loaded;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    exu_top i_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .inst_valid_i  (inst_valid),
        .inst_i        (inst),
        .pc_i          (pc),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .sys_evt_o     (sys_evt)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s test %0d: got 0x%08h expected 0x%08h",
                     name, cur_test, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "Output differs from the expected value");
        end
    endtask

    task automatic check_outputs(input logic [31:0] e_wb_valid, input logic [31:0] e_rd,
                                 input logic [31:0] e_data, input logic [31:0] e_redir,
                                 input logic [31:0] e_redir_pc, input logic [31:0] e_sys);
        check_value("wb_valid_o", 32'(wb_valid), e_wb_valid);
        check_value("wb_rd_o", 32'(wb_rd), e_rd);
        check_value("wb_data_o", wb_data, e_data);
        check_value("redirect_o", 32'(redirect), e_redir);
        check_value("redirect_pc_o", redirect_pc, e_redir_pc);
        check_value("sys_evt_o", 32'(sys_evt), e_sys);
    endtask

    // Drive on a falling edge, return at the next one with outputs settled
    task automatic drive(input logic valid, input logic [31:0] instr, input logic [31:0] addr);
        inst_valid = valid;
        inst       = instr;
        pc         = addr;
        @(negedge clk);
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v_inst;
        logic [31:0] v_pc;
        logic [31:0] v_wbv;
        logic [31:0] v_rd;
        logic [31:0] v_data;
        logic [31:0] v_rdr;
        logic [31:0] v_rpc;
        logic [31:0] v_sys;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %s", TEST_FILE);
            $display("SIMULATION FAILED");
            $fatal(1, "Test file missing");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", v_inst, v_pc, v_wbv,
                            v_rd, v_data, v_rdr, v_rpc, v_sys);       // '#' lines give 0
                if (n == 8) begin
                    t_inst.push_back(v_inst);
                    t_pc.push_back(v_pc);
                    t_wb_valid.push_back(v_wbv);
                    t_wb_rd.push_back(v_rd);
                    t_wb_data.push_back(v_data);
                    t_redir.push_back(v_rdr);
                    t_redir_pc.push_back(v_rpc);
                    t_sys.push_back(v_sys);
                end else if (n > 0) begin
                    $display("Test file line has %0d fields instead of 8: %s", n, line);
                    $display("SIMULATION FAILED");
                    $fatal(1, "Malformed test file");
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int idle;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        cur_test   = -1;                                    // -1 is the reset check
        load_tests();
        if (t_inst.size() == 0) begin
            $display("The test file holds no test lines");
            $display("SIMULATION FAILED");
            $fatal(1, "No tests");
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_outputs(32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0);  // Reset values
        arst_n = 1'b1;
        for (int i = 0; i < t_inst.size(); i++) begin
            cur_test = i;
            idle = {$random(seed)} % 3;
            repeat (idle) begin                             // Garbage word, no strobe
                drive(1'b0, $random(seed), $random(seed));
                check_outputs(32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0);
            end
            drive(1'b1, t_inst[i], t_pc[i]);
            check_outputs(t_wb_valid[i], t_wb_rd[i], t_wb_data[i],
                          t_redir[i], t_redir_pc[i], t_sys[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog, sized from the number of test lines
    initial begin
        wait (loaded);
        repeat (t_inst.size() * CYCLES_PER_TEST + 10) @(posedge clk);
        $display("Timeout after %0d cycles with %0d tests", 
                 t_inst.size() * CYCLES_PER_TEST + 10, t_inst.size());
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: tb/exu_tests.txt
# Columns, all hex: inst pc wb_valid wb_rd wb_data redirect redirect_pc sys_evt
# sys_evt bits: 0 ECALL, 1 EBREAK, 2 MRET, 3 FENCE, 4 ILLEGAL
00500093 00000100 1 01 00000005 0 00000000 00  # addi x1, x0, 5
FFD00113 00000104 1 02 FFFFFFFD 0 00000000 00  # addi x2, x0, -3
002081B3 00000108 1 03 00000002 0 00000000 00  # add x3, x1, x2
40208233 0000010C 1 04 00000008 0 00000000 00  # sub x4, x1, x2
00309293 00000110 1 05 00000028 0 00000000 00  # slli x5, x1, 3
00415313 00000114 1 06 0FFFFFFF 0 00000000 00  # srli x6, x2, 4
40415393 00000118 1 07 FFFFFFFF 0 00000000 00  # srai x7, x2, 4
00309433 0000011C 1 08 00000014 0 00000000 00  # sll x8, x1, x3
003154B3 00000120 1 09 3FFFFFFF 0 00000000 00  # srl x9, x2, x3
00112533 00000124 1 0A 00000001 0 00000000 00  # slt x10, x2, x1
001135B3 00000128 1 0B 00000000 0 00000000 00  # sltu x11, x2, x1
FFF0B613 0000012C 1 0C 00000001 0 00000000 00  # sltiu x12, x1, -1
0020C6B3 00000130 1 0D FFFFFFF8 0 00000000 00  # xor x13, x1, x2
0040E733 00000134 1 0E 0000000D 0 00000000 00  # or x14, x1, x4
0F017793 00000138 1 0F 000000F0 0 00000000 00  # andi x15, x2, 0xf0
FFF0C813 0000013C 1 10 FFFFFFFA 0 00000000 00  # xori x16, x1, -1
123458B7 00000140 1 11 12345000 0 00000000 00  # lui x17, 0x12345
00001917 00000144 1 12 00001144 0 00000000 00  # auipc x18, 0x1
00209863 00000148 0 00 00000000 1 00000158 00  # bne x1, x2, +16 taken
00208863 0000014C 0 00 00000000 0 00000000 00  # beq x1, x2, +16 not taken
FE114CE3 00000150 0 00 00000000 1 00000148 00  # blt x2, x1, -8 taken
FE116CE3 00000154 0 00 00000000 0 00000000 00  # bltu x2, x1, -8 not taken
0220D063 00000158 0 00 00000000 1 00000178 00  # bge x1, x2, +32 taken
0220F063 0000015C 0 00 00000000 0 00000000 00  # bgeu x1, x2, +32 not taken
0020E463 00000160 0 00 00000000 1 00000168 00  # bltu x1, x2, +8 taken
100009EF 00000164 1 13 00000168 1 00000264 00  # jal x19, +256
FFDFFA6F 00000168 1 14 0000016C 1 00000164 00  # jal x20, -4
00988AE7 0000016C 1 15 00000170 1 12345008 00  # jalr x21, 9(x17), bit 0 cleared
FFF20B67 00000170 1 16 00000174 1 00000006 00  # jalr x22, -1(x4)
00708013 00000174 0 00 00000000 0 00000000 00  # addi x0, x1, 7
0080006F 00000178 0 00 00000000 1 00000180 00  # jal x0, +8
40100BB3 0000017C 1 17 FFFFFFFB 0 00000000 00  # sub x23, x0, x1
01498C33 00000180 1 18 000002D4 0 00000000 00  # add x24, x19, x20
00000073 00000184 0 00 00000000 0 00000000 01  # ecall
00100073 00000188 0 00 00000000 0 00000000 02  # ebreak
30200073 0000018C 0 00 00000000 0 00000000 04  # mret
0FF0000F 00000190 0 00 00000000 0 00000000 08  # fence
00012083 00000194 0 00 00000000 0 00000000 10  # lw x1, 0(x2), no LSU
00000000 00000198 0 00 00000000 0 00000000 10  # all-zero word
30529073 0000019C 0 00 00000000 0 00000000 10  # csrrw x0, mtvec, x5
00008C93 000001A0 1 19 00000005 0 00000000 00  # addi x25, x1, 0
02208D33 000001A4 0 00 00000000 0 00000000 10  # mul x26, x1, x2
0000100F 000001A8 0 00 00000000 0 00000000 00  # fence.i
